//--- filelist.f
logic/mips_id_pkg.sv
logic/inst_decoder.sv
logic/operand_select.sv
logic/regfile.sv
logic/id_ex_latch.sv
logic/id_stage.sv
testbench/id_stage_asserts.sv
testbench/tb_id_stage.sv

//--- logic/id_ex_latch.sv
`timescale 1ns/1ns

module id_ex_latch
    import mips_id_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  dec_ctrl_t         ctrl_i,
    input  word_t      [1:0]  data_i,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output id_out_t           out_o
);

    logic load;     // transfer from decode
    logic move_we;  // write enable after the move rule

    // empty, or the held item leaves this edge
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign load       = in_valid_i && in_ready_o;

    // movn/movz look at the selected rt value
    always_comb begin
        move_we = ctrl_i.we;
        if (ctrl_i.aluop == OP_MOVN) begin
            move_we = (data_i[1] != '0);
        end else if (ctrl_i.aluop == OP_MOVZ) begin
            move_we = (data_i[1] == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_o <= in_valid_i;  // refill or go empty
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_o.aluop   <= ctrl_i.aluop;
            out_o.alusel  <= ctrl_i.alusel;
            out_o.we      <= move_we;
            out_o.waddr   <= ctrl_i.waddr;
            out_o.data1   <= data_i[0];
            out_o.data2   <= data_i[1];
            out_o.illegal <= ctrl_i.illegal;
        end
    end

endmodule

//--- logic/id_stage.sv
`timescale 1ns/1ns

module id_stage
    import mips_id_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  inst_t     inst_i,
    input  logic      inst_valid_i,
    output logic      inst_ready_o,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      mem_fwd_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_waddr_i,
    input  word_t     wb_wdata_i,
    output id_out_t   out_o,
    output logic      out_valid_o,
    input  logic      out_ready_i
);

    dec_ctrl_t        ctrl;
    rd_req_t   [1:0]  rd_req;   // 0 = rs port, 1 = rt port
    word_t     [1:0]  rdata;
    word_t     [1:0]  operand;

    inst_decoder u_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    for (genvar g = 0; g < 2; g++) begin : gen_operand
        assign rd_req[g] = '{re: ctrl.re[g], raddr: ctrl.raddr[g]};

        operand_select u_sel (
            .req_i     (rd_req[g]),
            .imm_i     (ctrl.imm),
            .rdata_i   (rdata[g]),
            .ex_fwd_i  (ex_fwd_i),
            .mem_fwd_i (mem_fwd_i),
            .data_o    (operand[g])
        );
    end

    regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .rd_req_i   (rd_req),
        .rdata_o    (rdata),
        .wb_we_i    (wb_we_i),
        .wb_waddr_i (wb_waddr_i),
        .wb_wdata_i (wb_wdata_i)
    );

    id_ex_latch u_latch (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (inst_valid_i),
        .in_ready_o  (inst_ready_o),
        .ctrl_i      (ctrl),
        .data_i      (operand),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_o       (out_o)
    );

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder
    import mips_id_pkg::*;
(
    input  inst_t     inst_i,
    output dec_ctrl_t ctrl_o
);

    logic [5:0]  op;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  sa;
    logic [5:0]  func;
    word_t       imm_zext;
    word_t       imm_sext;
    word_t       imm_upper;

    logic        r_hit;   // register-register form recognised
    alu_op_t     r_op;
    alu_sel_t    r_sel;
    logic        i_hit;   // immediate form recognised
    alu_op_t     i_op;
    alu_sel_t    i_sel;
    word_t       i_imm;
    logic        sh_hit;  // shift by sa
    alu_op_t     sh_op;

    assign op   = inst_i[31:26];
    assign rs   = inst_i[25:21];
    assign rt   = inst_i[20:16];
    assign rd   = inst_i[15:11];
    assign sa   = inst_i[10:6];
    assign func = inst_i[5:0];

    assign imm_zext  = {16'h0000, inst_i[15:0]};
    assign imm_sext  = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_upper = {inst_i[15:0], 16'h0000};  // lui

    // SPECIAL group, both operands from registers
    always_comb begin
        r_hit = 1'b1;
        r_op  = OP_NOP;
        r_sel = SEL_NOP;
        case (func)
            FN_AND: begin
                r_op  = OP_AND;
                r_sel = SEL_LOGIC;
            end
            FN_OR: begin
                r_op  = OP_OR;
                r_sel = SEL_LOGIC;
            end
            FN_XOR: begin
                r_op  = OP_XOR;
                r_sel = SEL_LOGIC;
            end
            FN_NOR: begin
                r_op  = OP_NOR;
                r_sel = SEL_LOGIC;
            end
            FN_SLLV: begin
                r_op  = OP_SLL;
                r_sel = SEL_SHIFT;
            end
            FN_SRLV: begin
                r_op  = OP_SRL;
                r_sel = SEL_SHIFT;
            end
            FN_SRAV: begin
                r_op  = OP_SRA;
                r_sel = SEL_SHIFT;
            end
            FN_ADD: begin
                r_op  = OP_ADD;
                r_sel = SEL_ARITH;
            end
            FN_ADDU: begin
                r_op  = OP_ADDU;
                r_sel = SEL_ARITH;
            end
            FN_SUB: begin
                r_op  = OP_SUB;
                r_sel = SEL_ARITH;
            end
            FN_SUBU: begin
                r_op  = OP_SUBU;
                r_sel = SEL_ARITH;
            end
            FN_SLT: begin
                r_op  = OP_SLT;
                r_sel = SEL_ARITH;
            end
            FN_SLTU: begin
                r_op  = OP_SLTU;
                r_sel = SEL_ARITH;
            end
            FN_MOVN: begin
                r_op  = OP_MOVN;
                r_sel = SEL_MOVE;
            end
            FN_MOVZ: begin
                r_op  = OP_MOVZ;
                r_sel = SEL_MOVE;
            end
            default: r_hit = 1'b0;  // includes dropped hi/lo, mult, sync
        endcase
    end

    // I-type, rs op imm -> rt
    always_comb begin
        i_hit = 1'b1;
        i_op  = OP_NOP;
        i_sel = SEL_NOP;
        i_imm = '0;
        case (op)
            OPC_ANDI: begin
                i_op  = OP_AND;
                i_sel = SEL_LOGIC;
                i_imm = imm_zext;
            end
            OPC_ORI: begin
                i_op  = OP_OR;
                i_sel = SEL_LOGIC;
                i_imm = imm_zext;
            end
            OPC_XORI: begin
                i_op  = OP_XOR;
                i_sel = SEL_LOGIC;
                i_imm = imm_zext;
            end
            OPC_LUI: begin
                i_op  = OP_OR;  // rs | (imm << 16)
                i_sel = SEL_LOGIC;
                i_imm = imm_upper;
            end
            OPC_ADDI: begin
                i_op  = OP_ADD;
                i_sel = SEL_ARITH;
                i_imm = imm_sext;
            end
            OPC_ADDIU: begin
                i_op  = OP_ADDU;
                i_sel = SEL_ARITH;
                i_imm = imm_sext;
            end
            OPC_SLTI: begin
                i_op  = OP_SLT;
                i_sel = SEL_ARITH;
                i_imm = imm_sext;
            end
            OPC_SLTIU: begin
                i_op  = OP_SLTU;
                i_sel = SEL_ARITH;
                i_imm = imm_sext;
            end
            default: i_hit = 1'b0;  // pref, SPECIAL2 and unknown
        endcase
    end

    // sll/srl/sra need op and rs both zero
    always_comb begin
        sh_hit = (inst_i[31:21] == 11'b0);
        sh_op  = OP_NOP;
        case (func)
            FN_SLL:  sh_op = OP_SLL;
            FN_SRL:  sh_op = OP_SRL;
            FN_SRA:  sh_op = OP_SRA;
            default: sh_hit = 1'b0;
        endcase
    end

    always_comb begin
        ctrl_o          = '0;
        ctrl_o.aluop    = OP_NOP;
        ctrl_o.alusel   = SEL_NOP;
        ctrl_o.waddr    = rd;   // default destination
        ctrl_o.raddr[0] = rs;
        ctrl_o.raddr[1] = rt;
        ctrl_o.illegal  = 1'b1; // cleared by any match below
        if (sh_hit) begin
            ctrl_o.aluop    = sh_op;
            ctrl_o.alusel   = SEL_SHIFT;
            ctrl_o.we       = 1'b1;
            ctrl_o.re[1]    = 1'b1;  // only rt
            ctrl_o.imm[4:0] = sa;
            ctrl_o.illegal  = 1'b0;
        end else if ((op == OPC_SPECIAL) && r_hit) begin
            ctrl_o.aluop   = r_op;
            ctrl_o.alusel  = r_sel;
            ctrl_o.we      = 1'b1;   // movn/movz resolved in the latch
            ctrl_o.re      = 2'b11;
            ctrl_o.illegal = 1'b0;
        end else if (i_hit) begin
            ctrl_o.aluop   = i_op;
            ctrl_o.alusel  = i_sel;
            ctrl_o.we      = 1'b1;
            ctrl_o.waddr   = rt;
            ctrl_o.re[0]   = 1'b1;
            ctrl_o.imm     = i_imm;
            ctrl_o.illegal = 1'b0;
        end
    end

endmodule

//--- logic/mips_id_pkg.sv
package mips_id_pkg;

    // plain vector types
    typedef logic [31:0] word_t;      // data word
    typedef logic [31:0] inst_t;      // instruction word
    typedef logic [4:0]  reg_addr_t;  // register number
    typedef logic [7:0]  alu_op_t;    // ALU operation code
    typedef logic [2:0]  alu_sel_t;   // result class

    localparam int REG_COUNT = 32;    // architectural registers

    // primary opcodes, inst[31:26]
    localparam logic [5:0] OPC_SPECIAL = 6'b000000;
    localparam logic [5:0] OPC_ADDI    = 6'b001000;
    localparam logic [5:0] OPC_ADDIU   = 6'b001001;
    localparam logic [5:0] OPC_SLTI    = 6'b001010;
    localparam logic [5:0] OPC_SLTIU   = 6'b001011;
    localparam logic [5:0] OPC_ANDI    = 6'b001100;
    localparam logic [5:0] OPC_ORI     = 6'b001101;
    localparam logic [5:0] OPC_XORI    = 6'b001110;
    localparam logic [5:0] OPC_LUI     = 6'b001111;

    // SPECIAL function codes, inst[5:0]
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_MOVZ = 6'b001010;
    localparam logic [5:0] FN_MOVN = 6'b001011;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    // ALU operation codes seen by the execute stage
    localparam alu_op_t OP_NOP  = 8'b00000000;
    localparam alu_op_t OP_AND  = 8'b00100100;
    localparam alu_op_t OP_OR   = 8'b00100101;
    localparam alu_op_t OP_XOR  = 8'b00100110;
    localparam alu_op_t OP_NOR  = 8'b00100111;
    localparam alu_op_t OP_SLL  = 8'b01111100;
    localparam alu_op_t OP_SRL  = 8'b00000010;
    localparam alu_op_t OP_SRA  = 8'b00000011;
    localparam alu_op_t OP_ADD  = 8'b00100000;
    localparam alu_op_t OP_ADDU = 8'b00100001;
    localparam alu_op_t OP_SUB  = 8'b00100010;
    localparam alu_op_t OP_SUBU = 8'b00100011;
    localparam alu_op_t OP_SLT  = 8'b00101010;
    localparam alu_op_t OP_SLTU = 8'b00101011;
    localparam alu_op_t OP_MOVN = 8'b00001011;
    localparam alu_op_t OP_MOVZ = 8'b00001010;

    // result classes
    localparam alu_sel_t SEL_NOP   = 3'b000;
    localparam alu_sel_t SEL_LOGIC = 3'b001;
    localparam alu_sel_t SEL_SHIFT = 3'b010;
    localparam alu_sel_t SEL_MOVE  = 3'b011;
    localparam alu_sel_t SEL_ARITH = 3'b100;

    // write-back result forwarded from a later stage
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } fwd_t;

    // one register file read request
    typedef struct packed {
        logic      re;
        reg_addr_t raddr;
    } rd_req_t;

    // decoder output, index 0 is rs side, index 1 is rt side
    typedef struct packed {
        alu_op_t         aluop;
        alu_sel_t        alusel;
        logic            we;
        reg_addr_t       waddr;
        logic [1:0]      re;
        reg_addr_t [1:0] raddr;
        word_t           imm;
        logic            illegal;
    } dec_ctrl_t;

    // what the stage hands to execute
    typedef struct packed {
        alu_op_t   aluop;
        alu_sel_t  alusel;
        logic      we;
        reg_addr_t waddr;
        word_t     data1;
        word_t     data2;
        logic      illegal;
    } id_out_t;

endpackage

//--- logic/operand_select.sv
`timescale 1ns/1ns

module operand_select
    import mips_id_pkg::*;
(
    input  rd_req_t req_i,
    input  word_t   imm_i,
    input  word_t   rdata_i,
    input  fwd_t    ex_fwd_i,
    input  fwd_t    mem_fwd_i,
    output word_t   data_o
);

    logic ex_hit;
    logic mem_hit;

    // r0 is compared like any other register
    assign ex_hit  = ex_fwd_i.we && (ex_fwd_i.waddr == req_i.raddr);
    assign mem_hit = mem_fwd_i.we && (mem_fwd_i.waddr == req_i.raddr);

    always_comb begin
        if (!req_i.re) begin
            data_o = imm_i;              // port unused, take immediate
        end else if (ex_hit) begin
            data_o = ex_fwd_i.wdata;     // previous instruction's result
        end else if (mem_hit) begin
            data_o = mem_fwd_i.wdata;    // one further back
        end else begin
            data_o = rdata_i;
        end
    end

endmodule

//--- logic/regfile.sv
`timescale 1ns/1ns

module regfile
    import mips_id_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  rd_req_t   [1:0]  rd_req_i,
    output word_t     [1:0]  rdata_o,
    input  logic             wb_we_i,
    input  reg_addr_t        wb_waddr_i,
    input  word_t            wb_wdata_i
);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we_i && (wb_waddr_i != '0)) begin  // r0 stays zero
            regs[wb_waddr_i] <= wb_wdata_i;
        end
    end

    // read sees the value before a same-cycle write
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (rd_req_i[p].re && (rd_req_i[p].raddr != '0)) begin
                rdata_o[p] = regs[rd_req_i[p].raddr];
            end else begin
                rdata_o[p] = '0;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the id_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_id_stage \
    -f filelist.f --Mdir obj_dir -o tb_id_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_id_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0

//--- testbench/id_stage_asserts.sv
`timescale 1ns/1ns

module id_stage_asserts
    import mips_id_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    out_valid_i,
    input  logic    out_ready_i,
    input  id_out_t out_i
);

    // nothing leaves the stage straight after reset
    valid_low_after_reset: assert property (@(posedge clk) rst |=> !out_valid_i)
        else $error("out_valid_o was high in the cycle after reset");

    // held item must not move while execute stalls
    hold_under_backpressure: assert property (@(posedge clk) disable iff (rst)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_i))
        else $error("out_o or out_valid_o changed under back-pressure");

    illegal_never_writes: assert property (@(posedge clk) disable iff (rst)
        out_valid_i && out_i.illegal |-> !out_i.we)
        else $error("illegal instruction left the stage with its write enable set");

endmodule

//--- testbench/tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage
    import mips_id_pkg::*;
();

    localparam int NUM_INST    = 2000;
    localparam int CYCLE_LIMIT = 20000;
    localparam int DRAIN_LIMIT = 64;

    // kept SPECIAL functions, movz twice to fill 16 slots
    localparam logic [15:0][5:0] R_FUNCS = {
        FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD,
        FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU, FN_MOVN, FN_MOVZ, FN_MOVZ
    };
    localparam logic [7:0][5:0] I_OPCS = {
        OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI, OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU
    };
    localparam logic [3:0][5:0] SH_FUNCS = {FN_SLL, FN_SRL, FN_SRA, FN_SLL};
    // {opcode, function}: mfhi, mflo, mult, multu, sync, mul, pref, unknown
    localparam logic [7:0][11:0] BAD_CODES = {
        {OPC_SPECIAL, 6'h10}, {OPC_SPECIAL, 6'h12}, {OPC_SPECIAL, 6'h18},
        {OPC_SPECIAL, 6'h19}, {OPC_SPECIAL, 6'h0f}, {6'h1c, 6'h02},
        {6'h33, 6'h00}, {6'h3f, 6'h00}
    };

    logic      clk;
    logic      rst;
    inst_t     inst_i;
    logic      inst_valid_i;
    logic      inst_ready_o;
    fwd_t      ex_fwd_i;
    fwd_t      mem_fwd_i;
    logic      wb_we_i;
    reg_addr_t wb_waddr_i;
    word_t     wb_wdata_i;
    id_out_t   out_o;
    logic      out_valid_o;
    logic      out_ready_i;

    logic [31:0] rng_state;
    word_t       model_regs [32];
    id_out_t     expect_q [$];
    logic        held;          // instruction waiting for ready
    int          accepted;
    int          checks;
    int          errors;
    int          timeouts;
    int          cycles;
    int          waited;

    id_stage UUT (
        .clk          (clk),
        .rst          (rst),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .ex_fwd_i     (ex_fwd_i),
        .mem_fwd_i    (mem_fwd_i),
        .wb_we_i      (wb_we_i),
        .wb_waddr_i   (wb_waddr_i),
        .wb_wdata_i   (wb_wdata_i),
        .out_o        (out_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i)
    );

    bind id_stage id_stage_asserts u_asserts (
        .clk         (clk),
        .rst         (rst),
        .out_valid_i (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_i       (out_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // registers 0..7 only, so forwards hit often
    function automatic inst_t random_inst();
        logic [31:0] r;
        logic [31:0] r2;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [11:0] bad;
        r  = next_rand();
        r2 = next_rand();
        rs = {2'b00, r[2:0]};
        rt = {2'b00, r[5:3]};
        rd = {2'b00, r[8:6]};
        if (r[12:9] < 4'd6) begin
            return {OPC_SPECIAL, rs, rt, rd, 5'd0, R_FUNCS[r[16:13]]};
        end else if (r[12:9] < 4'd10) begin
            return {I_OPCS[r[15:13]], rs, rt, r2[15:0]};
        end else if (r[12:9] < 4'd12) begin
            return {11'd0, rt, rd, r2[4:0], SH_FUNCS[r[14:13]]};
        end else if (r[12:9] == 4'd12) begin
            return {OPC_SPECIAL, rs | 5'd1, rt, rd, r2[4:0], SH_FUNCS[r[14:13]]};  // rs set
        end
        bad = BAD_CODES[r[15:13]];
        return {bad[11:6], rs, rt, rd, 5'd0, bad[5:0]};
    endfunction

    function automatic fwd_t random_fwd();
        logic [31:0] r;
        fwd_t        f;
        r       = next_rand();
        f.we    = r[0];
        f.waddr = {2'b00, r[3:1]};
        f.wdata = r[4] ? next_rand() : 32'd0;  // zero feeds movz
        return f;
    endfunction

    // {known, aluop, alusel}
    function automatic logic [11:0] op_class(logic [5:0] op, logic [5:0] func);
        logic [11:0] m;
        m = {1'b0, OP_NOP, SEL_NOP};
        if (op == OPC_SPECIAL) begin
            case (func)
                FN_AND:  m = {1'b1, OP_AND, SEL_LOGIC};
                FN_OR:   m = {1'b1, OP_OR, SEL_LOGIC};
                FN_XOR:  m = {1'b1, OP_XOR, SEL_LOGIC};
                FN_NOR:  m = {1'b1, OP_NOR, SEL_LOGIC};
                FN_SLLV: m = {1'b1, OP_SLL, SEL_SHIFT};
                FN_SRLV: m = {1'b1, OP_SRL, SEL_SHIFT};
                FN_SRAV: m = {1'b1, OP_SRA, SEL_SHIFT};
                FN_ADD:  m = {1'b1, OP_ADD, SEL_ARITH};
                FN_ADDU: m = {1'b1, OP_ADDU, SEL_ARITH};
                FN_SUB:  m = {1'b1, OP_SUB, SEL_ARITH};
                FN_SUBU: m = {1'b1, OP_SUBU, SEL_ARITH};
                FN_SLT:  m = {1'b1, OP_SLT, SEL_ARITH};
                FN_SLTU: m = {1'b1, OP_SLTU, SEL_ARITH};
                FN_MOVN: m = {1'b1, OP_MOVN, SEL_MOVE};
                FN_MOVZ: m = {1'b1, OP_MOVZ, SEL_MOVE};
                default: m = {1'b0, OP_NOP, SEL_NOP};
            endcase
        end else begin
            case (op)
                OPC_ANDI:  m = {1'b1, OP_AND, SEL_LOGIC};
                OPC_ORI:   m = {1'b1, OP_OR, SEL_LOGIC};
                OPC_XORI:  m = {1'b1, OP_XOR, SEL_LOGIC};
                OPC_LUI:   m = {1'b1, OP_OR, SEL_LOGIC};
                OPC_ADDI:  m = {1'b1, OP_ADD, SEL_ARITH};
                OPC_ADDIU: m = {1'b1, OP_ADDU, SEL_ARITH};
                OPC_SLTI:  m = {1'b1, OP_SLT, SEL_ARITH};
                OPC_SLTIU: m = {1'b1, OP_SLTU, SEL_ARITH};
                default:   m = {1'b0, OP_NOP, SEL_NOP};
            endcase
        end
        return m;
    endfunction

    // ex forward, then mem forward, then registers
    function automatic word_t operand_value(logic re, reg_addr_t a, word_t imm);
        if (!re) return imm;
        if (ex_fwd_i.we && (ex_fwd_i.waddr == a)) return ex_fwd_i.wdata;
        if (mem_fwd_i.we && (mem_fwd_i.waddr == a)) return mem_fwd_i.wdata;
        return (a == 5'd0) ? 32'd0 : model_regs[a];
    endfunction

    function automatic id_out_t expected_out(inst_t inst);
        id_out_t     e;
        logic [11:0] m;
        logic [1:0]  re;     // bit 0 rs, bit 1 rt
        word_t       immw;
        logic [5:0]  func;
        func      = inst[5:0];
        m         = op_class(inst[31:26], func);
        e         = '0;
        e.aluop   = m[10:3];
        e.alusel  = m[2:0];
        e.we      = m[11];
        e.illegal = !m[11];
        e.waddr   = inst[15:11];
        re        = 2'b00;
        immw      = '0;
        if ((inst[31:21] == 11'd0) && (func == FN_SLL || func == FN_SRL || func == FN_SRA)) begin
            e.aluop   = (func == FN_SLL) ? OP_SLL : ((func == FN_SRL) ? OP_SRL : OP_SRA);
            e.alusel  = SEL_SHIFT;
            e.we      = 1'b1;
            e.illegal = 1'b0;
            re        = 2'b10;
            immw      = {27'd0, inst[10:6]};  // sa
        end else if (m[11] && (inst[31:26] == OPC_SPECIAL)) begin
            re = 2'b11;
        end else if (m[11]) begin
            re      = 2'b01;
            e.waddr = inst[20:16];
            if (inst[31:26] == OPC_LUI) begin
                immw = {inst[15:0], 16'h0000};
            end else if (m[2:0] == SEL_LOGIC) begin
                immw = {16'h0000, inst[15:0]};
            end else begin
                immw = {{16{inst[15]}}, inst[15:0]};
            end
        end
        e.data1 = operand_value(re[0], inst[25:21], immw);
        e.data2 = operand_value(re[1], inst[20:16], immw);
        if (e.aluop == OP_MOVN) begin
            e.we = (e.data2 != 32'd0);
        end else if (e.aluop == OP_MOVZ) begin
            e.we = (e.data2 == 32'd0);
        end
        return e;
    endfunction

    task automatic drive_random(input logic allow_inst);
        logic [31:0] r;
        r = next_rand();
        if (!held) begin
            inst_valid_i <= allow_inst && (r[1:0] != 2'd0);
            inst_i       <= random_inst();
        end
        out_ready_i <= (r[4:2] > 3'd2);
        ex_fwd_i    <= random_fwd();
        mem_fwd_i   <= random_fwd();
        wb_we_i     <= (r[6:5] == 2'd0);
        wb_waddr_i  <= {2'b00, r[9:7]};
        wb_wdata_i  <= r[10] ? next_rand() : 32'd0;
    endtask

    // sampled at the falling edge, ahead of the next transfer edge
    task automatic check_cycle();
        id_out_t exp;
        logic    exp_valid;
        logic    exp_ready;
        exp_valid = (expect_q.size() != 0);  // one-deep latch, latency 1
        exp_ready = !exp_valid || out_ready_i;
        assert (out_valid_o === exp_valid) else begin
            errors++;
            $display("FAILED out_valid_o expected %h got %h", exp_valid, out_valid_o);
        end
        assert (inst_ready_o === exp_ready) else begin
            errors++;
            $display("FAILED inst_ready_o expected %h got %h", exp_ready, inst_ready_o);
        end
        if (out_valid_o && out_ready_i) begin
            assert (expect_q.size() != 0) else begin
                errors++;
                $display("output transfer with no instruction outstanding");
            end
            if (expect_q.size() != 0) begin
                exp = expect_q.pop_front();
                checks++;
                assert (out_o === exp) else begin
                    errors++;
                    $display("FAILED out_o expected %h got %h", exp, out_o);
                end
            end
        end
        held = inst_valid_i && !inst_ready_o;
        if (inst_valid_i && inst_ready_o) begin
            expect_q.push_back(expected_out(inst_i));  // reads see pre-write regs
            accepted++;
        end
        if (wb_we_i && (wb_waddr_i != 5'd0)) begin
            model_regs[wb_waddr_i] = wb_wdata_i;
        end
    endtask

    initial begin
        rng_state    = 32'd40755;
        rst          = 1'b1;
        inst_i       = '0;
        inst_valid_i = 1'b1;  // valid during reset must not load the latch
        ex_fwd_i     = '0;
        mem_fwd_i    = '0;
        wb_we_i      = 1'b0;
        wb_waddr_i   = '0;
        wb_wdata_i   = '0;
        out_ready_i  = 1'b0;
        held         = 1'b0;
        accepted     = 0;
        checks       = 0;
        errors       = 0;
        timeouts     = 0;
        cycles       = 0;
        waited       = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst          <= 1'b0;
        inst_valid_i <= 1'b0;

        while ((accepted < NUM_INST) && (cycles < CYCLE_LIMIT)) begin
            @(posedge clk);
            drive_random(1'b1);
            @(negedge clk);
            check_cycle();
            cycles++;
        end
        if (accepted < NUM_INST) begin
            timeouts++;
            $display("timeout: only %0d of %0d instructions were accepted", accepted, NUM_INST);
        end

        while (((expect_q.size() != 0) || held) && (waited < DRAIN_LIMIT)) begin
            @(posedge clk);
            drive_random(1'b0);
            @(negedge clk);
            check_cycle();
            waited++;
        end
        if ((expect_q.size() != 0) || held) begin
            timeouts++;
            $display("timeout: %0d accepted instructions never came out", expect_q.size());
        end

        $display("accepted %0d, checked %0d, errors %0d, timeouts %0d",
                 accepted, checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
